// File: switch.f
noc_pkg.sv
input_buffers.sv
route_table.sv
credit_counters.sv
switch_ctrl.sv
crossbar.sv
switch.sv
tb_switch.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_switch
FILELIST  ?= switch.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing
PASS_LINE ?= ^TEST RESULT: PASS$$

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_LINE)"

clean:
	rm -rf $(BUILD_DIR)

// File: switch_stim.txt
# inject <port> <vc> <flit hex> | credit <port> <vc> | wait <cycles>
# expect_count <output port> <vc> <total flits seen so far>
wait 5
inject 0 0 11800001
inject 1 1 11800002
inject 2 0 13800003
inject 3 1 14800004
wait 30
expect_count 0 0 2
expect_count 0 1 2
credit 0 0
credit 0 0
credit 0 1
credit 0 1
inject 1 0 c29c0002
inject 2 1 c2a40003
wait 30
inject 0 0 13800005
inject 3 1 13800006
inject 1 1 14800007
inject 2 0 c31c0001
inject 3 0 12800008
wait 30
expect_count 2 0 1
expect_count 2 1 1
expect_count 3 1 1
expect_count 0 0 4
credit 0 0
credit 0 0
credit 2 0
credit 2 1
credit 3 1
inject 1 0 11800009
inject 1 0 1180000a
inject 1 0 1180000b
inject 1 0 1180000c
wait 30
expect_count 0 0 8
inject 0 0 1180000d
inject 0 0 1180000e
inject 0 0 1180000f
inject 0 0 11800010
inject 0 1 11800011
inject 2 0 13800012
wait 30
expect_count 0 0 8
expect_count 0 1 3
expect_count 2 0 2
credit 0 0
wait 20
expect_count 0 0 9
credit 0 0
credit 0 0
credit 0 0
wait 30
expect_count 0 0 12

// File: tb_switch.sv
`timescale 1ns/1ns
`default_nettype none

module tb_switch import noc_pkg::*; ();

    localparam int       NPORTS          = 4;
    localparam int       DEPTH           = 4;
    localparam int       NQUEUES         = NUM_VCS * NPORTS;
    localparam node_id_t THIS_NODE       = 5;
    localparam int       CYCLES_PER_LINE = 200;

    typedef struct packed {
        flit_t flit;
        vc_t   vc;
        int    port;
        int    queue;
        int    seq;
    } expected_t;

    logic                              clk;
    logic                              rst;
    flit_t [NPORTS-1:0]                in_flit;
    vc_t   [NPORTS-1:0]                in_vc;
    logic  [NPORTS-1:0]                in_valid;
    logic  [NPORTS-1:0][NUM_VCS-1:0]   credit_in;
    flit_t [NPORTS-1:0]                out_flit;
    vc_t   [NPORTS-1:0]                out_vc;
    logic  [NPORTS-1:0]                out_valid;
    logic  [NPORTS-1:0][NUM_VCS-1:0]   buffer_available;
    logic  [NPORTS-1:0][NUM_VCS-1:0]   credit_out;

    // Scoreboard and reference model
    expected_t pending[$];
    port_id_t  ref_table [32];
    int        occupancy [NQUEUES];
    int        last_seq [NQUEUES];
    int        forwarded [NQUEUES];
    int        claimed [NQUEUES];
    int        credits_back [NQUEUES];
    int        out_count [NPORTS][NUM_VCS];
    int        errors       = 0;
    int        checks       = 0;
    int        next_seq     = 0;
    int        stim_lines   = 0;
    bit        stim_counted = 1'b0;
    int        seed         = 32'hf0295bec;

    switch #(
        .NUM_PORTS   (NPORTS),
        .BUFFER_DEPTH(DEPTH),
        .TOTAL_NODES (32),
        .NODE        (THIS_NODE)
    ) u_dut (
        .clk             (clk),
        .rst             (rst),
        .in_flit         (in_flit),
        .in_vc           (in_vc),
        .in_valid        (in_valid),
        .credit_in       (credit_in),
        .out_flit        (out_flit),
        .out_vc          (out_vc),
        .out_valid       (out_valid),
        .buffer_available(buffer_available),
        .credit_out      (credit_out)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Claimed configs update the reference table and are never expected out
    task automatic record_flit(input int p, input int v, input flit_t f);
        int        q;
        expected_t e;
        q = v * NPORTS + p;
        if (f[31:28] == FMT_SWITCH_CFG && f[27:23] == THIS_NODE) begin
            ref_table[f[22:18]] = f[2:0];
            claimed[q]++;
        end else begin
            e.flit  = f;
            e.vc    = vc_t'(v);
            e.port  = int'(ref_table[f[27:23]]);
            e.queue = q;
            e.seq   = next_seq;
            pending.push_back(e);
        end
        next_seq++;
    endtask

    task automatic match_output(input int p);
        int found;
        int q;
        found = -1;
        for (int i = 0; i < pending.size(); i++) begin
            if (found < 0 && pending[i].port == p && pending[i].flit == out_flit[p] &&
                pending[i].vc == out_vc[p]) begin
                found = i;
            end
        end
        checks++;
        if (found < 0) begin
            errors++;
            $display("** Error at %0t: unexpected flit %h vc %0d on port %0d",
                     $time, out_flit[p], out_vc[p], p);
        end else begin
            q = pending[found].queue;
            if (pending[found].seq <= last_seq[q]) begin
                errors++;
                $display("** Error at %0t: flit %h from queue %0d left out of order",
                         $time, out_flit[p], q);
            end
            last_seq[q] = pending[found].seq;
            forwarded[q]++;
            pending.delete(found);
        end
    endtask

    // Occupancy follows writes and returned credits
    task automatic track_queue(input int p, input int v);
        int   q;
        logic expect_avail;
        q = v * NPORTS + p;
        if (credit_out[p][v]) begin
            credits_back[q]++;
            if (occupancy[q] == 0) begin
                errors++;
                $display("** Error at %0t: credit_out[%0d][%0d] on an empty queue",
                         $time, p, v);
            end else begin
                occupancy[q]--;
            end
        end
        expect_avail = (occupancy[q] != DEPTH);
        checks++;
        if (buffer_available[p][v] != expect_avail) begin
            errors++;
            $display("** Error at %0t: buffer_available[%0d][%0d] is %b, expected %b",
                     $time, p, v, buffer_available[p][v], expect_avail);
        end
        if (in_valid[p] && in_vc[p] == vc_t'(v)) begin
            occupancy[q]++;
        end
    endtask

    // Outputs sampled away from the driving edge
    always @(negedge clk) begin
        if (!rst) begin
            for (int p = 0; p < NPORTS; p++) begin
                if (out_valid[p]) begin
                    out_count[p][out_vc[p]]++;
                    match_output(p);
                end
            end
            for (int p = 0; p < NPORTS; p++) begin
                for (int v = 0; v < NUM_VCS; v++) begin
                    track_queue(p, v);
                end
            end
        end
    end

    task automatic run_line(input logic [8*128-1:0] text);
        string       op;
        int          n;
        int          a;
        int          b;
        int          cnt;
        flit_t       f;
        logic [31:0] rnd;
        n = $sscanf(text, "%s", op);
        if (n < 1 || op == "#") begin
            return;
        end
        @(posedge clk);
        in_valid  <= '0;
        credit_in <= '0;
        if (op == "inject") begin
            n   = $sscanf(text, "%s %d %d %h", op, a, b, f);
            rnd = $random(seed);
            // Random filler in the spare payload bits of data flits
            if (f[31:28] == FMT_DATA) begin
                f[17:8] = rnd[9:0];
            end
            in_flit[a]  <= f;
            in_vc[a]    <= vc_t'(b);
            in_valid[a] <= 1'b1;
            record_flit(a, b, f);
        end else if (op == "credit") begin
            n = $sscanf(text, "%s %d %d", op, a, b);
            credit_in[a][b] <= 1'b1;
        end else if (op == "wait") begin
            n = $sscanf(text, "%s %d", op, cnt);
            repeat (cnt - 1) @(posedge clk);
        end else if (op == "expect_count") begin
            n = $sscanf(text, "%s %d %d %d", op, a, b, cnt);
            checks++;
            if (out_count[a][b] != cnt) begin
                errors++;
                $display("** Error at %0t: port %0d vc %0d sent %0d flits, expected %0d",
                         $time, a, b, out_count[a][b], cnt);
            end
        end else begin
            errors++;
            $display("Unknown opcode %s in the stimulus file", op);
        end
    endtask

    task automatic check_credit_returns();
        for (int q = 0; q < NQUEUES; q++) begin
            checks++;
            if (credits_back[q] != forwarded[q] + claimed[q]) begin
                errors++;
                $display("** Error at %0t: queue %0d returned %0d credits for %0d pops",
                         $time, q, credits_back[q], forwarded[q] + claimed[q]);
            end
        end
    endtask

    initial begin
        int                fd;
        logic [8*128-1:0] text;
        in_flit   = '0;
        in_vc     = '0;
        in_valid  = '0;
        credit_in = '0;
        rst       = 1'b1;
        for (int i = 0; i < 32; i++) begin
            ref_table[i] = '0;
        end
        for (int q = 0; q < NQUEUES; q++) begin
            occupancy[q]    = 0;
            last_seq[q]     = -1;
            forwarded[q]    = 0;
            claimed[q]      = 0;
            credits_back[q] = 0;
        end
        for (int p = 0; p < NPORTS; p++) begin
            out_count[p][0] = 0;
            out_count[p][1] = 0;
        end
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        fd = $fopen("switch_stim.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("Could not open the stimulus file switch_stim.txt");
        end else begin
            while ($fgets(text, fd) != 0) begin
                stim_lines++;
            end
            $fclose(fd);
            stim_counted = 1'b1;
            fd = $fopen("switch_stim.txt", "r");
            while ($fgets(text, fd) != 0) begin
                run_line(text);
            end
            $fclose(fd);
            @(posedge clk);
            in_valid  <= '0;
            credit_in <= '0;
            // Wait until every expected flit has left
            while (pending.size() != 0) begin
                @(posedge clk);
            end
            repeat (10) @(posedge clk);
            check_credit_returns();
        end
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

    initial begin
        wait (stim_counted);
        repeat (stim_lines * CYCLES_PER_LINE) @(posedge clk);
        $display("Timeout: the run did not finish within %0d cycles",
                 stim_lines * CYCLES_PER_LINE);
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// File: switch.sv
`timescale 1ns/1ns
`default_nettype none

module switch import noc_pkg::*; #(
    parameter int       NUM_PORTS    = 4,
    parameter int       BUFFER_DEPTH = 4,
    parameter int       TOTAL_NODES  = 32,
    parameter node_id_t NODE         = 5
) (
    input  logic                                clk,
    input  logic                                rst,
    input  flit_t [NUM_PORTS-1:0]               in_flit,
    input  vc_t   [NUM_PORTS-1:0]               in_vc,
    input  logic  [NUM_PORTS-1:0]               in_valid,
    input  logic  [NUM_PORTS-1:0][NUM_VCS-1:0] credit_in,
    output flit_t [NUM_PORTS-1:0]               out_flit,
    output vc_t   [NUM_PORTS-1:0]               out_vc,
    output logic  [NUM_PORTS-1:0]               out_valid,
    output logic  [NUM_PORTS-1:0][NUM_VCS-1:0] buffer_available,
    output logic  [NUM_PORTS-1:0][NUM_VCS-1:0] credit_out
);

    localparam int NQ = NUM_VCS * NUM_PORTS;
    localparam int QW = $clog2(NQ);

    // Queue heads and pop
    flit_t [NQ-1:0] head_flit;
    logic  [NQ-1:0] head_valid;
    logic           pop;
    logic  [QW-1:0] pop_queue;

    // Route table
    node_id_t lookup_node;
    port_id_t lookup_port;
    logic     cfg_write;
    node_id_t cfg_node;
    port_id_t cfg_port;

    // Credits
    logic [NUM_PORTS-1:0][NUM_VCS-1:0] credit_ok;
    logic     send;
    port_id_t send_port;
    vc_t      send_vc;

    // Crossbar request
    logic     xbar_enable;
    port_id_t xbar_port;
    vc_t      xbar_vc;
    flit_t    xbar_flit;

    input_buffers #(
        .NUM_PORTS   (NUM_PORTS),
        .BUFFER_DEPTH(BUFFER_DEPTH)
    ) u_buffers (
        .clk             (clk),
        .rst             (rst),
        .in_flit         (in_flit),
        .in_vc           (in_vc),
        .in_valid        (in_valid),
        .pop             (pop),
        .pop_queue       (pop_queue),
        .head_flit       (head_flit),
        .head_valid      (head_valid),
        .buffer_available(buffer_available),
        .credit_out      (credit_out)
    );

    route_table #(
        .TOTAL_NODES(TOTAL_NODES)
    ) u_route_table (
        .clk        (clk),
        .rst        (rst),
        .lookup_node(lookup_node),
        .lookup_port(lookup_port),
        .cfg_write  (cfg_write),
        .cfg_node   (cfg_node),
        .cfg_port   (cfg_port)
    );

    credit_counters #(
        .NUM_PORTS   (NUM_PORTS),
        .BUFFER_DEPTH(BUFFER_DEPTH)
    ) u_credits (
        .clk      (clk),
        .rst      (rst),
        .send     (send),
        .send_port(send_port),
        .send_vc  (send_vc),
        .credit_in(credit_in),
        .credit_ok(credit_ok)
    );

    switch_ctrl #(
        .NUM_PORTS(NUM_PORTS),
        .NODE     (NODE)
    ) u_ctrl (
        .clk        (clk),
        .rst        (rst),
        .head_flit  (head_flit),
        .head_valid (head_valid),
        .pop        (pop),
        .pop_queue  (pop_queue),
        .lookup_node(lookup_node),
        .lookup_port(lookup_port),
        .cfg_write  (cfg_write),
        .cfg_node   (cfg_node),
        .cfg_port   (cfg_port),
        .credit_ok  (credit_ok),
        .send       (send),
        .send_port  (send_port),
        .send_vc    (send_vc),
        .xbar_enable(xbar_enable),
        .xbar_port  (xbar_port),
        .xbar_vc    (xbar_vc),
        .xbar_flit  (xbar_flit)
    );

    crossbar #(
        .NUM_PORTS(NUM_PORTS)
    ) u_crossbar (
        .clk        (clk),
        .rst        (rst),
        .xbar_enable(xbar_enable),
        .xbar_port  (xbar_port),
        .xbar_vc    (xbar_vc),
        .xbar_flit  (xbar_flit),
        .out_flit   (out_flit),
        .out_vc     (out_vc),
        .out_valid  (out_valid)
    );

endmodule

`default_nettype wire

// File: crossbar.sv
`timescale 1ns/1ns
`default_nettype none

module crossbar import noc_pkg::*; #(
    parameter int NUM_PORTS = 4
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  xbar_enable,
    input  port_id_t              xbar_port,
    input  vc_t                   xbar_vc,
    input  flit_t                 xbar_flit,
    output flit_t [NUM_PORTS-1:0] out_flit,
    output vc_t   [NUM_PORTS-1:0] out_vc,
    output logic  [NUM_PORTS-1:0] out_valid
);

    logic [NUM_PORTS-1:0] sel;

    // One-hot port select
    always_comb begin
        for (int p = 0; p < NUM_PORTS; p++) begin
            sel[p] = xbar_enable && (xbar_port == port_id_t'(p));
        end
    end

    // Data holds until the port is chosen again
    always_ff @(posedge clk) begin
        for (int p = 0; p < NUM_PORTS; p++) begin
            if (sel[p]) begin
                out_flit[p] <= xbar_flit;
                out_vc[p]   <= xbar_vc;
            end
        end
    end

    // Valid is a single-cycle strobe
    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= '0;
        end else begin
            out_valid <= sel;
        end
    end

endmodule

`default_nettype wire

// File: switch_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

module switch_ctrl import noc_pkg::*; #(
    parameter int       NUM_PORTS = 4,
    parameter node_id_t NODE      = 5
) (
    input  logic                                 clk,
    input  logic                                 rst,
    input  flit_t [NUM_VCS*NUM_PORTS-1:0]        head_flit,
    input  logic  [NUM_VCS*NUM_PORTS-1:0]        head_valid,
    output logic                                 pop,
    output logic  [$clog2(NUM_VCS*NUM_PORTS)-1:0] pop_queue,
    output node_id_t                             lookup_node,
    input  port_id_t                             lookup_port,
    output logic                                 cfg_write,
    output node_id_t                             cfg_node,
    output port_id_t                             cfg_port,
    input  logic  [NUM_PORTS-1:0][NUM_VCS-1:0]  credit_ok,
    output logic                                 send,
    output port_id_t                             send_port,
    output vc_t                                  send_vc,
    output logic                                 xbar_enable,
    output port_id_t                             xbar_port,
    output vc_t                                  xbar_vc,
    output flit_t                                xbar_flit
);

    localparam int NQ = NUM_VCS * NUM_PORTS;
    localparam int QW = $clog2(NQ);

    ctrl_state_t state;
    logic [QW-1:0] rr_ptr;
    logic [QW-1:0] cur_q;
    logic [QW-1:0] pick_q;
    logic          pick_found;
    flit_t         cur_flit;
    vc_t           cur_vc;
    logic          is_cfg;
    logic          credit_here;
    logic          in_send;

    // Round-robin pick, first valid head at or after rr_ptr
    always_comb begin
        int idx;
        pick_found = 1'b0;
        pick_q     = rr_ptr;
        for (int i = 0; i < NQ; i++) begin
            idx = (int'(rr_ptr) + i) % NQ;
            if (!pick_found && head_valid[idx]) begin
                pick_found = 1'b1;
                pick_q     = QW'(idx);
            end
        end
    end

    assign cur_flit = head_flit[cur_q];
    // Upper half of the queues is VC1
    assign cur_vc   = (int'(cur_q) >= NUM_PORTS);
    assign is_cfg   = (cur_flit[FMT_MSB:FMT_LSB] == FMT_SWITCH_CFG) &&
                      (cur_flit[DEST_MSB:DEST_LSB] == NODE);

    // A port outside the switch never gets credit
    assign credit_here = (int'(lookup_port) < NUM_PORTS) && credit_ok[lookup_port][cur_vc];
    assign in_send     = (state == SEND);

    assign lookup_node = cur_flit[DEST_MSB:DEST_LSB];

    assign cfg_write = in_send && is_cfg;
    assign cfg_node  = cur_flit[CFG_NODE_LSB +: $bits(node_id_t)];
    assign cfg_port  = cur_flit[CFG_PORT_LSB +: $bits(port_id_t)];

    assign send      = in_send && !is_cfg && credit_here;
    assign send_port = lookup_port;
    assign send_vc   = cur_vc;

    // Claimed or sent flits leave the queue, stalled ones stay
    assign pop       = cfg_write || send;
    assign pop_queue = cur_q;

    assign xbar_enable = send;
    assign xbar_port   = lookup_port;
    assign xbar_vc     = cur_vc;
    assign xbar_flit   = cur_flit;

    always_ff @(posedge clk) begin
        if (rst) begin
            state  <= IDLE;
            rr_ptr <= '0;
            cur_q  <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (pick_found) begin
                        cur_q <= pick_q;
                        state <= ROUTE;
                    end
                end
                ROUTE: begin
                    state <= SEND;
                end
                SEND: begin
                    // Move past this queue whatever the outcome
                    rr_ptr <= (int'(cur_q) == NQ - 1) ? '0 : cur_q + 1'b1;
                    state  <= IDLE;
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: credit_counters.sv
`timescale 1ns/1ns
`default_nettype none

module credit_counters import noc_pkg::*; #(
    parameter int NUM_PORTS    = 4,
    parameter int BUFFER_DEPTH = 4
) (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                send,
    input  port_id_t                            send_port,
    input  vc_t                                 send_vc,
    input  logic [NUM_PORTS-1:0][NUM_VCS-1:0]  credit_in,
    output logic [NUM_PORTS-1:0][NUM_VCS-1:0]  credit_ok
);

    for (genvar p = 0; p < NUM_PORTS; p++) begin : g_port
        for (genvar v = 0; v < NUM_VCS; v++) begin : g_vc
            credit_t count;
            logic    dec;
            logic    inc;

            assign dec = send && (send_port == port_id_t'(p)) && (send_vc == vc_t'(v));
            assign inc = credit_in[p][v];

            // Downstream queue starts empty, so full credit
            always_ff @(posedge clk) begin
                if (rst) begin
                    count <= credit_t'(BUFFER_DEPTH);
                end else begin
                    case ({inc, dec})
                        2'b10: begin
                            if (count != credit_t'(BUFFER_DEPTH)) begin
                                count <= count + 1'b1;
                            end
                        end
                        2'b01: begin
                            if (count != '0) begin
                                count <= count - 1'b1;
                            end
                        end
                        // Return and spend cancel out
                        default: count <= count;
                    endcase
                end
            end

            assign credit_ok[p][v] = (count != '0);
        end
    end

endmodule

`default_nettype wire

// File: route_table.sv
`timescale 1ns/1ns
`default_nettype none

module route_table import noc_pkg::*; #(
    parameter int TOTAL_NODES = 32
) (
    input  logic     clk,
    input  logic     rst,
    input  node_id_t lookup_node,
    output port_id_t lookup_port,
    input  logic     cfg_write,
    input  node_id_t cfg_node,
    input  port_id_t cfg_port
);

    port_id_t table_q [TOTAL_NODES];
    logic     lookup_in_range;
    logic     cfg_in_range;

    assign lookup_in_range = (int'(lookup_node) < TOTAL_NODES);
    assign cfg_in_range    = (int'(cfg_node) < TOTAL_NODES);

    // Entries come up as port 0
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < TOTAL_NODES; i++) begin
                table_q[i] <= '0;
            end
        end else if (cfg_write && cfg_in_range) begin
            table_q[cfg_node] <= cfg_port;
        end
    end

    // Registered read, result valid the cycle after lookup_node
    always_ff @(posedge clk) begin
        if (rst) begin
            lookup_port <= '0;
        end else if (lookup_in_range) begin
            lookup_port <= table_q[lookup_node];
        end else begin
            // Unknown node falls back to port 0
            lookup_port <= '0;
        end
    end

endmodule

`default_nettype wire

// File: input_buffers.sv
`timescale 1ns/1ns
`default_nettype none

module input_buffers import noc_pkg::*; #(
    parameter int NUM_PORTS    = 4,
    parameter int BUFFER_DEPTH = 4
) (
    input  logic                                 clk,
    input  logic                                 rst,
    input  flit_t [NUM_PORTS-1:0]                in_flit,
    input  vc_t   [NUM_PORTS-1:0]                in_vc,
    input  logic  [NUM_PORTS-1:0]                in_valid,
    input  logic                                 pop,
    input  logic  [$clog2(NUM_VCS*NUM_PORTS)-1:0] pop_queue,
    output flit_t [NUM_VCS*NUM_PORTS-1:0]        head_flit,
    output logic  [NUM_VCS*NUM_PORTS-1:0]        head_valid,
    output logic  [NUM_PORTS-1:0][NUM_VCS-1:0]  buffer_available,
    output logic  [NUM_PORTS-1:0][NUM_VCS-1:0]  credit_out
);

    localparam int NQ = NUM_VCS * NUM_PORTS;
    localparam int QW = $clog2(NQ);
    localparam int PW = (BUFFER_DEPTH > 1) ? $clog2(BUFFER_DEPTH) : 1;

    // Queue q serves port q % NUM_PORTS on VC q / NUM_PORTS
    for (genvar q = 0; q < NQ; q++) begin : g_queue
        localparam int P = q % NUM_PORTS;
        localparam int V = q / NUM_PORTS;

        flit_t         mem [BUFFER_DEPTH];
        logic [PW-1:0] rd_ptr;
        logic [PW-1:0] wr_ptr;
        credit_t       count;
        logic          wr_en;
        logic          rd_en;
        logic          credit_q;

        // Writes to a full queue are dropped
        assign wr_en = in_valid[P] && (in_vc[P] == vc_t'(V)) &&
                       (count != credit_t'(BUFFER_DEPTH));
        assign rd_en = pop && (pop_queue == QW'(q)) && (count != '0);

        always_ff @(posedge clk) begin
            if (wr_en) begin
                mem[wr_ptr] <= in_flit[P];
            end
        end

        always_ff @(posedge clk) begin
            if (rst) begin
                rd_ptr   <= '0;
                wr_ptr   <= '0;
                count    <= '0;
                credit_q <= 1'b0;
            end else begin
                if (wr_en) begin
                    wr_ptr <= (wr_ptr == PW'(BUFFER_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
                end
                if (rd_en) begin
                    rd_ptr <= (rd_ptr == PW'(BUFFER_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
                end
                case ({wr_en, rd_en})
                    2'b10:   count <= count + 1'b1;
                    2'b01:   count <= count - 1'b1;
                    default: count <= count;
                endcase
                // One credit back upstream per popped flit
                credit_q <= rd_en;
            end
        end

        assign head_flit[q]           = mem[rd_ptr];
        assign head_valid[q]          = (count != '0);
        assign buffer_available[P][V] = (count != credit_t'(BUFFER_DEPTH));
        assign credit_out[P][V]       = credit_q;
    end

endmodule

`default_nettype wire

// File: noc_pkg.sv
`default_nettype none

package noc_pkg;

    // Two VCs per port; queue indexing in the buffers depends on it
    localparam int NUM_VCS = 2;

    typedef logic [31:0] flit_t;
    typedef logic [4:0]  node_id_t;
    typedef logic [2:0]  port_id_t;
    typedef logic        vc_t;
    typedef logic [3:0]  credit_t;
    typedef logic [3:0]  fmt_t;

    // Flit fields
    localparam int FMT_MSB  = 31;
    localparam int FMT_LSB  = 28;
    localparam int DEST_MSB = 27;
    localparam int DEST_LSB = 23;

    // Format codes
    localparam fmt_t FMT_DATA       = 4'h1;
    localparam fmt_t FMT_SWITCH_CFG = 4'hC;

    // Config payload layout, table index and new port value
    localparam int CFG_NODE_LSB = 18;
    localparam int CFG_PORT_LSB = 0;

    typedef enum logic [1:0] {
        IDLE,
        ROUTE,
        SEND
    } ctrl_state_t;

endpackage

`default_nettype wire
